//--- design/obi_mem_pkg.sv
// OBI banked memory types
package obi_mem_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Host bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int be_w   = data_w / 8;

  // Word interleaved banks, selected by addr bits 3:2
  localparam int num_banks  = 4;
  localparam int bank_sel_w = $clog2(num_banks);

  // Words per bank, indexed by addr bits 9:4
  localparam int bank_words = 64;
  localparam int word_sel_w = $clog2(bank_words);

  // Lowest address bit of the bank field
  localparam int bank_lsb = $clog2(be_w);
  localparam int word_lsb = bank_lsb + bank_sel_w;

  // Accepted requests still waiting for their response
  localparam int order_depth = 4;
  localparam int order_ptr_w = $clog2(order_depth);

  // ----------------------------------------
  // Structs
  // ----------------------------------------

  // Host A channel payload, 1P1 fields only
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic              we;
    logic [be_w-1:0]   be;
    logic [data_w-1:0] wdata;
  } obi_req_t;

  // Command shared by all banks, qualified by a per-bank strobe
  typedef struct packed {
    logic [word_sel_w-1:0] word;
    logic                  we;
    logic [be_w-1:0]       be;
    logic [data_w-1:0]     wdata;
  } bank_cmd_t;

  // ----------------------------------------
  // Monitor codes
  // ----------------------------------------

  // Ordered by priority when several rules fail in one cycle
  typedef enum logic [2:0] {
    none,
    req_dropped,
    a_unstable,
    be_zero,
    be_gap,
    addr_be_mismatch,
    r_without_a
  } obi_violation_e;

endpackage

//--- design/obi_bank_router.sv
// OBI request router
`timescale 1ns/1ps

module obi_bank_router (
  input  logic                                   clk,
  input  logic                                   reset_n,
  input  logic                                   req,
  input  obi_mem_pkg::obi_req_t                  a_req,
  output logic                                   gnt,
  input  logic [obi_mem_pkg::num_banks-1:0]      rsp_pending,
  input  logic                                   order_full,
  output logic [obi_mem_pkg::num_banks-1:0]      cmd_valid,
  output obi_mem_pkg::bank_cmd_t                 cmd,
  output logic                                   push,
  output logic [obi_mem_pkg::bank_sel_w-1:0]     push_bank
);

  // Target bank of the current request
  logic [obi_mem_pkg::bank_sel_w-1:0] bank;
  // Banks holding or about to hold a response
  logic [obi_mem_pkg::num_banks-1:0]  bank_busy;
  // Strobes sent on the last edge
  logic [obi_mem_pkg::num_banks-1:0]  issued_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------

  assign bank = a_req.addr[obi_mem_pkg::bank_lsb +: obi_mem_pkg::bank_sel_w];

  // Command fields go to every bank, only the strobe is per bank
  assign cmd.word  = a_req.addr[obi_mem_pkg::word_lsb +: obi_mem_pkg::word_sel_w];
  assign cmd.we    = a_req.we;
  assign cmd.be    = a_req.be;
  assign cmd.wdata = a_req.wdata;

  // ----------------------------------------
  // Grant
  // ----------------------------------------

  // A bank commanded last edge counts as busy alongside its pending flag
  assign bank_busy = rsp_pending | issued_q;

  // Grant needs a free slot in the target bank and room in the order queue
  assign gnt = req && !bank_busy[bank] && !order_full;

  // One-hot strobe toward the target bank
  always_comb begin
    cmd_valid       = '0;
    cmd_valid[bank] = gnt;
  end

  // Merger records the bank so responses leave in grant order
  assign push      = gnt;
  assign push_bank = bank;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      issued_q <= '0;
    end else begin
      issued_q <= cmd_valid;
    end
  end

endmodule

//--- design/obi_mem_bank.sv
// OBI memory bank
`timescale 1ns/1ps

module obi_mem_bank (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           cmd_valid,
  input  obi_mem_pkg::bank_cmd_t         cmd,
  input  logic                           rsp_taken,
  output logic                           rsp_pending,
  output logic [obi_mem_pkg::data_w-1:0] rdata
);

  // Word storage, one lane per byte
  logic [obi_mem_pkg::data_w-1:0] mem [obi_mem_pkg::bank_words];

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd.we) begin
      for (int i = 0; i < obi_mem_pkg::be_w; i++) begin
        // Only enabled lanes change
        if (cmd.be[i]) begin
          mem[cmd.word][i*8 +: 8] <= cmd.wdata[i*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Response slot
  // ----------------------------------------

  // Reads capture the old word, writes answer with zero
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      rdata <= cmd.we ? '0 : mem[cmd.word];
    end
  end

  // Slot is full from the command edge until the merger takes it
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rsp_pending <= 1'b0;
    end else if (cmd_valid) begin
      rsp_pending <= 1'b1;
    end else if (rsp_taken) begin
      rsp_pending <= 1'b0;
    end
  end

endmodule

//--- design/obi_resp_merge.sv
// OBI in-order response merger
`timescale 1ns/1ps

module obi_resp_merge (
  input  logic                                                       clk,
  input  logic                                                       reset_n,
  input  logic                                                       push,
  input  logic [obi_mem_pkg::bank_sel_w-1:0]                         push_bank,
  input  logic [obi_mem_pkg::num_banks-1:0]                          rsp_pending,
  input  logic [obi_mem_pkg::num_banks-1:0][obi_mem_pkg::data_w-1:0] bank_rdata,
  input  logic                                                       rready,
  output logic                                                       order_full,
  output logic [obi_mem_pkg::num_banks-1:0]                          rsp_taken,
  output logic                                                       rvalid,
  output logic [obi_mem_pkg::data_w-1:0]                             rdata
);

  // Bank indices in grant order
  logic [obi_mem_pkg::bank_sel_w-1:0]  order_q [obi_mem_pkg::order_depth];
  logic [obi_mem_pkg::order_ptr_w-1:0] wr_ptr;
  logic [obi_mem_pkg::order_ptr_w-1:0] rd_ptr;
  // One extra bit so a full queue is distinct from empty
  logic [obi_mem_pkg::order_ptr_w:0]   count;
  logic [obi_mem_pkg::bank_sel_w-1:0]  head_bank;
  logic                                pop;

  // ----------------------------------------
  // Head selection
  // ----------------------------------------

  assign head_bank  = order_q[rd_ptr];
  assign order_full = (count == obi_mem_pkg::order_depth);

  // Head response is ready once its bank fills the slot
  assign rvalid = (count != '0) && rsp_pending[head_bank];
  assign rdata  = bank_rdata[head_bank];

  // R channel completes on rvalid and rready
  assign pop = rvalid && rready;

  always_comb begin
    rsp_taken            = '0;
    rsp_taken[head_bank] = pop;
  end

  // ----------------------------------------
  // Queue
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= push_bank;
    end
  end

  // Pointers wrap since the depth is a power of two
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- design/obi_protocol_monitor.sv
// OBI host bus monitor
`timescale 1ns/1ps

module obi_protocol_monitor (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        req,
  input  logic                        gnt,
  input  obi_mem_pkg::obi_req_t       a_req,
  input  logic                        rvalid,
  input  logic                        rready,
  output logic                        protocol_error,
  output obi_mem_pkg::obi_violation_e violation
);

  // Previous cycle of the A channel
  logic                        req_q;
  logic                        gnt_q;
  obi_mem_pkg::obi_req_t       a_req_q;
  // Accepted requests without a response yet
  logic [3:0]                  outstanding;
  // Highest priority rule failing this cycle
  obi_mem_pkg::obi_violation_e viol_now;
  logic                        waiting;

  // Index of the lowest enabled byte, zero when none is set
  function automatic logic [1:0] lowest_be(input logic [obi_mem_pkg::be_w-1:0] be);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = obi_mem_pkg::be_w - 1; i >= 0; i--) begin
      if (be[i]) idx = 2'(i);
    end
    return idx;
  endfunction

  // All set bits form one run
  function automatic logic be_contig(input logic [obi_mem_pkg::be_w-1:0] be);
    logic [obi_mem_pkg::be_w-1:0] run;
    run = be >> lowest_be(be);
    return (run & (run + 1'b1)) == '0;
  endfunction

  // ----------------------------------------
  // Rule checks
  // ----------------------------------------

  // Request seen last cycle without a grant
  assign waiting = req_q && !gnt_q;

  always_comb begin
    viol_now = obi_mem_pkg::none;
    if (waiting && !req) begin
      viol_now = obi_mem_pkg::req_dropped;
    end else if (waiting && (a_req != a_req_q)) begin
      viol_now = obi_mem_pkg::a_unstable;
    end else if (req && a_req.we && (a_req.be == '0)) begin
      viol_now = obi_mem_pkg::be_zero;
    end else if (req && a_req.we && !be_contig(a_req.be)) begin
      viol_now = obi_mem_pkg::be_gap;
    end else if (req && (a_req.addr[1:0] != lowest_be(a_req.be))) begin
      // Applies to reads as well as writes
      viol_now = obi_mem_pkg::addr_be_mismatch;
    end else if (rvalid && (outstanding == '0)) begin
      viol_now = obi_mem_pkg::r_without_a;
    end
  end

  // ----------------------------------------
  // State
  // ----------------------------------------

  always_ff @(posedge clk) begin
    a_req_q <= a_req;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_q          <= 1'b0;
      gnt_q          <= 1'b0;
      outstanding    <= '0;
      protocol_error <= 1'b0;
      violation      <= obi_mem_pkg::none;
    end else begin
      req_q <= req;
      gnt_q <= gnt;
      // Count up on an accepted A phase, down on a finished R phase
      if ((req && gnt) && !(rvalid && rready)) begin
        outstanding <= outstanding + 1'b1;
      end else if (!(req && gnt) && (rvalid && rready)) begin
        outstanding <= outstanding - 1'b1;
      end
      // First violation sticks until reset
      if (!protocol_error && (viol_now != obi_mem_pkg::none)) begin
        protocol_error <= 1'b1;
        violation      <= viol_now;
      end
    end
  end

endmodule

//--- design/obi_mem_top.sv
// OBI banked memory top
`timescale 1ns/1ps

module obi_mem_top (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        req,
  input  obi_mem_pkg::obi_req_t       a_req,
  output logic                        gnt,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [obi_mem_pkg::data_w-1:0] rdata,
  output logic                        protocol_error,
  output obi_mem_pkg::obi_violation_e violation
);

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------

  logic [obi_mem_pkg::num_banks-1:0]                          cmd_valid;
  obi_mem_pkg::bank_cmd_t                                     cmd;
  logic [obi_mem_pkg::num_banks-1:0]                          rsp_pending;
  logic [obi_mem_pkg::num_banks-1:0][obi_mem_pkg::data_w-1:0] bank_rdata;
  logic [obi_mem_pkg::num_banks-1:0]                          rsp_taken;
  logic                                                       push;
  logic [obi_mem_pkg::bank_sel_w-1:0]                         push_bank;
  logic                                                       order_full;

  obi_bank_router i_router (
    .clk         (clk),
    .reset_n     (reset_n),
    .req         (req),
    .a_req       (a_req),
    .gnt         (gnt),
    .rsp_pending (rsp_pending),
    .order_full  (order_full),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .push        (push),
    .push_bank   (push_bank)
  );

  // One bank per interleave slot
  for (genvar b = 0; b < obi_mem_pkg::num_banks; b++) begin : gen_bank
    obi_mem_bank i_bank (
      .clk         (clk),
      .reset_n     (reset_n),
      .cmd_valid   (cmd_valid[b]),
      .cmd         (cmd),
      .rsp_taken   (rsp_taken[b]),
      .rsp_pending (rsp_pending[b]),
      .rdata       (bank_rdata[b])
    );
  end

  obi_resp_merge i_merge (
    .clk         (clk),
    .reset_n     (reset_n),
    .push        (push),
    .push_bank   (push_bank),
    .rsp_pending (rsp_pending),
    .bank_rdata  (bank_rdata),
    .rready      (rready),
    .order_full  (order_full),
    .rsp_taken   (rsp_taken),
    .rvalid      (rvalid),
    .rdata       (rdata)
  );

  // Watches the host side of both channels
  obi_protocol_monitor i_monitor (
    .clk            (clk),
    .reset_n        (reset_n),
    .req            (req),
    .gnt            (gnt),
    .a_req          (a_req),
    .rvalid         (rvalid),
    .rready         (rready),
    .protocol_error (protocol_error),
    .violation      (violation)
  );

endmodule

//--- testbench/obi_tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps

module obi_tb_clock (
  output logic clk
);

  // 8 ns period, first rising edge at 4 ns
  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

endmodule

//--- testbench/obi_mem_props.sv
// Bank and order queue assertions
`timescale 1ns/1ps

module obi_mem_props (
  input logic                              clk,
  input logic                              reset_n,
  input logic [obi_mem_pkg::num_banks-1:0] cmd_valid,
  input logic [obi_mem_pkg::num_banks-1:0] rsp_pending,
  input logic [obi_mem_pkg::num_banks-1:0] rsp_taken,
  input logic                              push,
  input logic                              order_full
);

  // A command only lands in an empty response slot
  a_cmd_slot_free: assert property (@(posedge clk) disable iff (!reset_n)
    (cmd_valid & rsp_pending) == '0)
    else $error("Command sent to a bank that still holds a response");

  // At most one bank is popped per cycle
  a_taken_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0(rsp_taken))
    else $error("More than one bank response taken in one cycle");

  // Order queue never overflows
  a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
    !(push && order_full))
    else $error("Order queue pushed while full");

endmodule

bind obi_mem_top obi_mem_props i_props (
  .clk         (clk),
  .reset_n     (reset_n),
  .cmd_valid   (cmd_valid),
  .rsp_pending (rsp_pending),
  .rsp_taken   (rsp_taken),
  .push        (push),
  .order_full  (order_full)
);

//--- testbench/obi_mem_tb.sv
// OBI banked memory testbench
`timescale 1ns/1ps

module obi_mem_tb;

  localparam logic [31:0] rand_seed = 32'h8ba42a43;
  // First test runs 48 transfers at about 3 cycles each, the rest stay far below
  localparam int timeout_cycles = 2000;

  logic                        clk;
  logic                        reset_n;
  logic                        req;
  obi_mem_pkg::obi_req_t       a_req;
  logic                        gnt;
  logic                        rvalid;
  logic                        rready;
  logic [31:0]                 rdata;
  logic                        protocol_error;
  obi_mem_pkg::obi_violation_e violation;

  // Reference memory by word address, addr bits 9:2
  logic [31:0] model [256];
  // Expected rdata of granted requests, oldest first
  logic [31:0] exp_q [$];
  // Word addresses written by the first test, low two bits give the bank
  logic [7:0]  tested_w [16];
  int          checks;
  int          errors;
  int          cycles;

  obi_tb_clock i_clock (.clk(clk));

  obi_mem_top i_dut (.*);

  // ----------------------------------------
  // Checks and bus helpers
  // ----------------------------------------

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic do_reset();
    reset_n = 1'b0;
    req     = 1'b0;
    rready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    exp_q.delete();
  endtask

  task automatic drive_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata);
    req         = 1'b1;
    a_req.addr  = addr;
    a_req.we    = we;
    a_req.be    = be;
    a_req.wdata = wdata;
  endtask

  // Waits for gnt, then records the expected response from the model
  task automatic wait_gnt(output int waits);
    logic [7:0] w;
    waits = 0;
    @(negedge clk);
    while (!gnt) begin
      waits++;
      @(negedge clk);
    end
    w = a_req.addr[9:2];
    if (a_req.we) begin
      for (int k = 0; k < 4; k++) begin
        if (a_req.be[k]) model[w][k*8 +: 8] = a_req.wdata[k*8 +: 8];
      end
      // Writes answer with zero
      exp_q.push_back(32'h0);
    end else begin
      exp_q.push_back(model[w]);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send(input logic [31:0] addr, input logic we, input logic [3:0] be,
                      input logic [31:0] wdata, output int waits);
    drive_req(addr, we, be, wdata);
    wait_gnt(waits);
  endtask

  task automatic idle();
    req = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name, input int err_start);
    $display("Test %s done with %0d errors", name, errors - err_start);
  endtask

  // R channel completes on the edge after this sample
  always @(negedge clk) begin
    if (reset_n && rvalid && rready) begin
      if (exp_q.size() == 0) begin
        check_true(1'b0, "Response arrived with no request waiting for it");
      end else begin
        check_val("rdata", exp_q.pop_front(), rdata);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Run stopped after %0d cycles before the tests finished", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_write_read();
    int         e0;
    int         waits;
    int         lo;
    int         hi;
    logic [7:0] w;
    logic [3:0] be;
    e0 = errors;
    rready = 1'b1;
    for (int i = 0; i < 16; i++) begin
      // Low nibble from the loop keeps words distinct and covers every bank
      w  = {4'($urandom), 4'(i)};
      tested_w[i] = w;
      lo = $urandom % 4;
      hi = lo + $urandom % (4 - lo);
      be = 4'((1 << (hi + 1)) - (1 << lo));
      send({22'h0, w, 2'b00}, 1'b1, 4'hf, $urandom, waits);
      send({22'h0, w, 2'(lo)}, 1'b1, be, $urandom, waits);
      send({22'h0, w, 2'b00}, 1'b0, 4'hf, 32'h0, waits);
      idle();
    end
    drain();
    check_val("protocol_error", 32'h0, 32'(protocol_error));
    finish_test("write_read", e0);
  endtask

  task automatic test_pipeline();
    int e0;
    int waits;
    e0 = errors;
    rready = 1'b1;
    for (int i = 0; i < 4; i++) begin
      send({22'h0, tested_w[i], 2'b00}, 1'b0, 4'hf, 32'h0, waits);
      check_true(waits == 0, "Pipelined read was not granted in its first cycle");
    end
    idle();
    drain();
    check_val("protocol_error", 32'h0, 32'(protocol_error));
    finish_test("pipeline", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int waits;
    e0 = errors;
    rready = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send({22'h0, tested_w[i], 2'b00}, 1'b0, 4'hf, 32'h0, waits);
      check_true(waits == 0, "Read with a free queue slot was not granted at once");
    end
    // Fifth request finds the order queue full
    drive_req({22'h0, tested_w[4], 2'b00}, 1'b0, 4'hf, 32'h0);
    @(negedge clk);
    // Head response stays on the bus with the oldest expected word
    for (int c = 0; c < 3; c++) begin
      check_val("gnt", 32'h0, 32'(gnt));
      check_val("rvalid", 32'h1, 32'(rvalid));
      check_val("rdata", exp_q[0], rdata);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    wait_gnt(waits);
    idle();
    drain();
    check_val("protocol_error", 32'h0, 32'(protocol_error));
    finish_test("backpressure", e0);
  endtask

  task automatic test_same_bank();
    int e0;
    int waits;
    e0 = errors;
    rready = 1'b0;
    // Entries 5 and 9 share bank 1
    send({22'h0, tested_w[5], 2'b00}, 1'b0, 4'hf, 32'h0, waits);
    drive_req({22'h0, tested_w[9], 2'b00}, 1'b0, 4'hf, 32'h0);
    repeat (3) begin
      @(negedge clk);
      check_val("gnt", 32'h0, 32'(gnt));
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    wait_gnt(waits);
    idle();
    drain();
    check_val("protocol_error", 32'h0, 32'(protocol_error));
    finish_test("same_bank", e0);
  endtask

  // Violation latches on the edge after the offending cycle
  task automatic expect_violation(input obi_mem_pkg::obi_violation_e code);
    @(posedge clk);
    #1;
    idle();
    @(negedge clk);
    check_val("protocol_error", 32'h1, 32'(protocol_error));
    check_val("violation", 32'(code), 32'(violation));
  endtask

  task automatic test_violations();
    int e0;
    int waits;
    e0 = errors;
    do_reset();
    drive_req(32'h0, 1'b1, 4'h0, $urandom);
    expect_violation(obi_mem_pkg::be_zero);
    do_reset();
    drive_req(32'h0, 1'b1, 4'b0101, $urandom);
    expect_violation(obi_mem_pkg::be_gap);
    do_reset();
    drive_req(32'h1, 1'b0, 4'hf, 32'h0);
    expect_violation(obi_mem_pkg::addr_be_mismatch);
    // Fill the queue, then drop the waiting request
    do_reset();
    for (int i = 0; i < 4; i++) begin
      send({22'h0, tested_w[i], 2'b00}, 1'b0, 4'hf, 32'h0, waits);
    end
    drive_req({22'h0, tested_w[4], 2'b00}, 1'b0, 4'hf, 32'h0);
    @(negedge clk);
    check_val("gnt", 32'h0, 32'(gnt));
    @(posedge clk);
    #1;
    idle();
    expect_violation(obi_mem_pkg::req_dropped);
    do_reset();
    finish_test("violations", e0);
  endtask

  // ----------------------------------------
  // Run
  // ----------------------------------------

  initial begin
    void'($urandom(rand_seed));
    checks = 0;
    errors = 0;
    cycles = 0;
    a_req  = '0;
    do_reset();
    test_write_read();
    test_pipeline();
    test_backpressure();
    test_same_bank();
    test_violations();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/obi_mem_pkg.sv
design/obi_bank_router.sv
design/obi_mem_bank.sv
design/obi_resp_merge.sv
design/obi_protocol_monitor.sv
design/obi_mem_top.sv
testbench/obi_tb_clock.sv
testbench/obi_mem_props.sv
testbench/obi_mem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the OBI memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module obi_mem_tb -o obi_mem_sim

./obj_dir/obi_mem_sim | tee sim.log

# Result is taken from the log
grep -q "All checks passed" sim.log
